// ==== design/mem_ui_pkg.sv ====
package mem_ui_pkg;

  // controller user interface widths
  localparam int ui_addr_w = 27;
  localparam int ui_data_w = 64; // two 32-bit lanes

  // one beat per command, so app_addr steps by a full beat
  localparam logic [ui_addr_w-1:0] addr_inc = 27'd8;

  localparam logic [2:0] cmd_write = 3'b000;
  localparam logic [2:0] cmd_read  = 3'b001;

  localparam int pass_shift = 16;

  // --------------------
  // data pattern
  // --------------------

  // seed plus beat index plus the pass index moved into the upper half
  function automatic logic [31:0] pattern_word(input logic [31:0] seed,
                                               input logic [31:0] beat,
                                               input logic [15:0] pass);
    logic [31:0] pass_term;
    pass_term = 32'(pass) << pass_shift;
    return seed + beat + pass_term;
  endfunction

endpackage

// ==== design/tester_regs_pkg.sv ====
package tester_regs_pkg;

  localparam int axil_addr_w = 6;

  // register map, all word aligned
  localparam logic [axil_addr_w-1:0] ctrl_ofs           = 6'h00;
  localparam logic [axil_addr_w-1:0] start_addr_ofs     = 6'h04;
  localparam logic [axil_addr_w-1:0] end_addr_ofs       = 6'h08; // inclusive
  localparam logic [axil_addr_w-1:0] passes_ofs         = 6'h0C;
  localparam logic [axil_addr_w-1:0] seed_ofs           = 6'h10;
  localparam logic [axil_addr_w-1:0] status_ofs         = 6'h14;
  localparam logic [axil_addr_w-1:0] pass_cnt_ofs       = 6'h18;
  localparam logic [axil_addr_w-1:0] err_cnt_ofs        = 6'h1C;
  localparam logic [axil_addr_w-1:0] first_err_addr_ofs = 6'h20;

  // ctrl bits, start clears itself
  localparam int ctrl_start_bit    = 0;
  localparam int ctrl_stop_err_bit = 1;

  // status bits
  localparam int status_busy_bit      = 0;
  localparam int status_done_bit      = 1;
  localparam int status_error_bit     = 2;
  localparam int status_heartbeat_bit = 3;

  localparam logic [1:0] axi_resp_okay = 2'b00;

endpackage

// ==== design/ui_traffic_gen.sv ====
`timescale 1ns/1ps

module ui_traffic_gen import mem_ui_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pass_start,
  input  logic [ui_addr_w-1:0] start_addr,
  input  logic [ui_addr_w-1:0] end_addr,
  input  logic [31:0]          seed,
  input  logic [15:0]          pass_idx,
  input  logic                 app_rdy,
  input  logic                 app_wdf_rdy,
  output logic                 app_en,
  output logic                 app_wdf_wren,
  output logic                 app_wdf_end,
  output logic [2:0]           app_cmd,
  output logic [ui_addr_w-1:0] app_addr,
  output logic [ui_data_w-1:0] app_wdf_data,
  output logic                 issue_done,
  output logic [31:0]          rd_issued
);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read,
    st_done
  } state_t;

  state_t      state;
  logic [31:0] beat_idx;
  logic [31:0] wr_word;
  logic        last_beat;
  logic        en_hold;
  logic        wren_hold;

  assign last_beat = (app_addr >= end_addr);

  // each request stays up until its own acceptance
  assign en_hold   = app_en && !app_rdy;
  assign wren_hold = app_wdf_wren && !app_wdf_rdy;

  assign wr_word      = pattern_word(seed, beat_idx, pass_idx);
  assign app_wdf_data = {2{wr_word}}; // same word in both lanes
  assign app_wdf_end  = app_wdf_wren;

  // --------------------
  // pass sequencing
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= st_idle;
      app_en       <= 1'b0;
      app_wdf_wren <= 1'b0;
      issue_done   <= 1'b0;
      rd_issued    <= '0;
    end else if (pass_start) begin
      state        <= st_write;
      app_en       <= 1'b1;
      app_wdf_wren <= 1'b1;
      issue_done   <= 1'b0;
      rd_issued    <= '0;
    end else begin
      case (state)
        st_write: begin
          if (!en_hold && !wren_hold) begin
            if (last_beat) begin
              state        <= st_read; // back to start_addr for the read sweep
              app_en       <= 1'b1;
              app_wdf_wren <= 1'b0;
            end else begin
              app_en       <= 1'b1;
              app_wdf_wren <= 1'b1;
            end
          end else begin
            app_en       <= en_hold;
            app_wdf_wren <= wren_hold;
          end
        end
        st_read: begin
          if (app_rdy) begin
            rd_issued <= rd_issued + 32'd1;
            if (last_beat) begin
              app_en     <= 1'b0;
              issue_done <= 1'b1;
              state      <= st_done;
            end
          end
        end
        default: ; // idle and done wait for the next pass_start
      endcase
    end
  end

  // address, command and beat index carry no reset
  always_ff @(posedge clk) begin
    if (pass_start) begin
      app_addr <= start_addr;
      app_cmd  <= cmd_write;
      beat_idx <= '0;
    end else if (state == st_write && !en_hold && !wren_hold) begin
      if (last_beat) begin
        app_addr <= start_addr;
        app_cmd  <= cmd_read;
      end else begin
        app_addr <= app_addr + addr_inc;
        beat_idx <= beat_idx + 32'd1;
      end
    end else if (state == st_read && app_rdy && !last_beat) begin
      app_addr <= app_addr + addr_inc; // reads go out back to back
    end
  end

  // --------------------
  // assertions
  // --------------------

  a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
    app_en && !app_rdy |=> $stable(app_addr) && $stable(app_cmd));

  a_wdata_stable: assert property (@(posedge clk) disable iff (reset)
    app_wdf_wren && !app_wdf_rdy |=> $stable(app_wdf_data));

endmodule

// ==== design/rd_data_checker.sv ====
`timescale 1ns/1ps

module rd_data_checker import mem_ui_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pass_start,
  input  logic [ui_addr_w-1:0] start_addr,
  input  logic [31:0]          seed,
  input  logic [15:0]          pass_idx,
  input  logic                 app_rd_data_valid,
  input  logic [ui_data_w-1:0] app_rd_data,
  output logic [31:0]          rd_returned,
  output logic                 mismatch,
  output logic [ui_addr_w-1:0] mismatch_addr
);

  logic                 armed; // set by the first pass_start
  logic [ui_addr_w-1:0] exp_addr;
  logic [31:0]          exp_word;
  logic                 beat_bad;

  // returns come back in issue order, so the return count is the beat index
  assign exp_word = pattern_word(seed, rd_returned, pass_idx);
  assign beat_bad = (app_rd_data != {2{exp_word}});

  always_ff @(posedge clk) begin
    if (reset) begin
      armed       <= 1'b0;
      rd_returned <= '0;
      mismatch    <= 1'b0;
    end else begin
      mismatch <= 1'b0;
      if (pass_start) begin
        armed       <= 1'b1;
        rd_returned <= '0;
      end else if (app_rd_data_valid && armed) begin
        rd_returned <= rd_returned + 32'd1;
        mismatch    <= beat_bad;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pass_start) begin
      exp_addr <= start_addr;
    end else if (app_rd_data_valid) begin
      mismatch_addr <= exp_addr; // address of the beat just compared
      exp_addr      <= exp_addr + addr_inc;
    end
  end

  // --------------------
  // assertions
  // --------------------

  // nothing can be in flight before the generator has run a pass
  a_no_early_return: assert property (@(posedge clk) disable iff (reset)
    !armed |-> !app_rd_data_valid);

endmodule

// ==== design/tester_csr.sv ====
`timescale 1ns/1ps

module tester_csr import mem_ui_pkg::*, tester_regs_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [axil_addr_w-1:0] s_awaddr,
  input  logic                   s_awvalid,
  output logic                   s_awready,
  input  logic [31:0]            s_wdata,
  input  logic [3:0]             s_wstrb,
  input  logic                   s_wvalid,
  output logic                   s_wready,
  output logic [1:0]             s_bresp,
  output logic                   s_bvalid,
  input  logic                   s_bready,
  input  logic [axil_addr_w-1:0] s_araddr,
  input  logic                   s_arvalid,
  output logic                   s_arready,
  output logic [31:0]            s_rdata,
  output logic [1:0]             s_rresp,
  output logic                   s_rvalid,
  input  logic                   s_rready,
  output logic                   pass_start,
  output logic [ui_addr_w-1:0]   start_addr,
  output logic [ui_addr_w-1:0]   end_addr,
  output logic [31:0]            seed,
  output logic [15:0]            pass_idx,
  input  logic                   issue_done,
  input  logic [31:0]            rd_issued,
  input  logic [31:0]            rd_returned,
  input  logic                   mismatch,
  input  logic [ui_addr_w-1:0]   mismatch_addr,
  output logic                   busy,
  output logic                   done,
  output logic                   error,
  output logic                   heartbeat
);

  logic                 stop_on_error;
  logic [31:0]          passes;
  logic [31:0]          pass_cnt;
  logic [31:0]          err_cnt;
  logic [ui_addr_w-1:0] first_err_addr;
  logic                 pass_active;
  logic                 pass_end;
  logic                 start_hit;
  logic [31:0]          rd_word;
  logic [31:0]          aw_old;
  logic [31:0]          wr_word;

  function automatic logic [31:0] reg_read(input logic [axil_addr_w-1:0] ofs);
    logic [31:0] word;
    word = '0; // unused offsets read zero
    case (ofs)
      ctrl_ofs:           word[ctrl_stop_err_bit] = stop_on_error;
      start_addr_ofs:     word = 32'(start_addr);
      end_addr_ofs:       word = 32'(end_addr);
      passes_ofs:         word = passes;
      seed_ofs:           word = seed;
      status_ofs: begin
        word[status_busy_bit]      = busy;
        word[status_done_bit]      = done;
        word[status_error_bit]     = error;
        word[status_heartbeat_bit] = heartbeat;
      end
      pass_cnt_ofs:       word = pass_cnt;
      err_cnt_ofs:        word = err_cnt;
      first_err_addr_ofs: word = 32'(first_err_addr);
      default: ;
    endcase
    return word;
  endfunction

  // --------------------
  // AXI4-Lite write
  // --------------------

  assign s_wready = s_awready; // address and data are taken together
  assign s_bresp  = axi_resp_okay;

  always_comb begin
    aw_old = reg_read(s_awaddr);
    for (int i = 0; i < 4; i++) begin
      wr_word[8*i +: 8] = s_wstrb[i] ? s_wdata[8*i +: 8] : aw_old[8*i +: 8];
    end
  end

  // a start is ignored while a run is in progress
  assign start_hit = s_awready && (s_awaddr == ctrl_ofs) && s_wstrb[0] &&
                     s_wdata[ctrl_start_bit] && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      s_awready     <= 1'b0;
      s_bvalid      <= 1'b0;
      stop_on_error <= 1'b0;
    end else begin
      s_awready <= !s_awready && !s_bvalid && s_awvalid && s_wvalid;
      if (s_awready) begin
        s_bvalid <= 1'b1;
        if (s_awaddr == ctrl_ofs) stop_on_error <= wr_word[ctrl_stop_err_bit];
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_awready) begin
      case (s_awaddr)
        start_addr_ofs: start_addr <= wr_word[ui_addr_w-1:0];
        end_addr_ofs:   end_addr   <= wr_word[ui_addr_w-1:0];
        passes_ofs:     passes     <= wr_word;
        seed_ofs:       seed       <= wr_word;
        default: ; // read-only and unused offsets
      endcase
    end
  end

  // --------------------
  // AXI4-Lite read
  // --------------------

  assign s_arready = !s_rvalid;
  assign s_rresp   = axi_resp_okay;

  always_comb rd_word = reg_read(s_araddr);

  always_ff @(posedge clk) begin
    if (reset)
      s_rvalid <= 1'b0;
    else if (s_arvalid && s_arready)
      s_rvalid <= 1'b1;
    else if (s_rready)
      s_rvalid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (s_arvalid && s_arready) s_rdata <= rd_word;
  end

  // --------------------
  // pass sequencing
  // --------------------

  // the last read has come back once the return count catches up
  assign pass_end = pass_active && issue_done && (rd_returned == rd_issued);
  assign pass_idx = pass_cnt[15:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      pass_start  <= 1'b0;
      pass_active <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
      error       <= 1'b0;
      heartbeat   <= 1'b0;
      pass_cnt    <= '0;
      err_cnt     <= '0;
    end else begin
      pass_start <= 1'b0;
      if (start_hit) begin
        pass_start <= 1'b1;
        pass_cnt   <= '0;
        err_cnt    <= '0;
        error      <= 1'b0;
        done       <= 1'b0;
      end else begin
        if (pass_start) begin
          pass_active <= 1'b1;
          busy        <= 1'b1;
        end
        if (mismatch) begin
          error <= 1'b1;
          if (err_cnt != '1) err_cnt <= err_cnt + 32'd1; // saturates
        end
        if (pass_end) begin
          pass_active <= 1'b0;
          pass_cnt    <= pass_cnt + 32'd1;
          heartbeat   <= ~heartbeat;
          // a mismatch on the final beat arrives in this same cycle
          if ((pass_cnt + 32'd1 >= passes) || (stop_on_error && (error || mismatch))) begin
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            pass_start <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mismatch && err_cnt == '0) first_err_addr <= mismatch_addr;
  end

  // the generator and checker must finish a pass before another begins
  a_no_restart_in_pass: assert property (@(posedge clk) disable iff (reset)
    pass_start && busy |-> issue_done && (rd_returned == rd_issued));

endmodule

// ==== design/mem_tester_top.sv ====
`timescale 1ns/1ps

module mem_tester_top import mem_ui_pkg::*, tester_regs_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  // register port
  input  logic [axil_addr_w-1:0] s_awaddr,
  input  logic                   s_awvalid,
  output logic                   s_awready,
  input  logic [31:0]            s_wdata,
  input  logic [3:0]             s_wstrb,
  input  logic                   s_wvalid,
  output logic                   s_wready,
  output logic [1:0]             s_bresp,
  output logic                   s_bvalid,
  input  logic                   s_bready,
  input  logic [axil_addr_w-1:0] s_araddr,
  input  logic                   s_arvalid,
  output logic                   s_arready,
  output logic [31:0]            s_rdata,
  output logic [1:0]             s_rresp,
  output logic                   s_rvalid,
  input  logic                   s_rready,
  // controller user interface
  input  logic                   app_rdy,
  output logic                   app_en,
  output logic [2:0]             app_cmd,
  output logic [ui_addr_w-1:0]   app_addr,
  input  logic                   app_wdf_rdy,
  output logic                   app_wdf_wren,
  output logic                   app_wdf_end,
  output logic [ui_data_w-1:0]   app_wdf_data,
  input  logic                   app_rd_data_valid,
  input  logic [ui_data_w-1:0]   app_rd_data,
  output logic                   error,
  output logic                   heartbeat,
  output logic                   busy
);

  logic                 pass_start;
  logic [ui_addr_w-1:0] start_addr;
  logic [ui_addr_w-1:0] end_addr;
  logic [31:0]          seed;
  logic [15:0]          pass_idx;
  logic                 issue_done;
  logic [31:0]          rd_issued;
  logic [31:0]          rd_returned;
  logic                 mismatch;
  logic [ui_addr_w-1:0] mismatch_addr;

  // done is seen through the status register only
  tester_csr u_csr (
    .clk, .reset,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .pass_start, .start_addr, .end_addr, .seed, .pass_idx,
    .issue_done, .rd_issued, .rd_returned, .mismatch, .mismatch_addr,
    .busy, .done(), .error, .heartbeat
  );

  ui_traffic_gen u_gen (
    .clk, .reset, .pass_start, .start_addr, .end_addr, .seed, .pass_idx,
    .app_rdy, .app_wdf_rdy, .app_en, .app_wdf_wren, .app_wdf_end,
    .app_cmd, .app_addr, .app_wdf_data, .issue_done, .rd_issued
  );

  rd_data_checker u_chk (
    .clk, .reset, .pass_start, .start_addr, .seed, .pass_idx,
    .app_rd_data_valid, .app_rd_data, .rd_returned, .mismatch, .mismatch_addr
  );

endmodule

// ==== tb/ui_mem_model.sv ====
`timescale 1ns/1ps

module ui_mem_model import mem_ui_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 app_en,
  input  logic [2:0]           app_cmd,
  input  logic [ui_addr_w-1:0] app_addr,
  output logic                 app_rdy,
  input  logic                 app_wdf_wren,
  input  logic                 app_wdf_end,
  input  logic [ui_data_w-1:0] app_wdf_data,
  output logic                 app_wdf_rdy,
  output logic                 app_rd_data_valid,
  output logic [ui_data_w-1:0] app_rd_data,
  input  logic                 stall_en,
  input  logic                 new_run,
  input  logic                 fault_en,
  input  logic [ui_addr_w-1:0] fault_addr,
  input  logic [ui_addr_w-1:0] range_lo,
  input  logic [ui_addr_w-1:0] range_hi,
  input  logic [31:0]          check_seed,
  output int                   check_errs
);

  logic [ui_data_w-1:0] mem [logic [ui_addr_w-1:0]];
  logic [ui_addr_w-1:0] rd_q [$];
  int unsigned          due_q [$];
  int unsigned          cyc;
  int unsigned          pass_seen;

  initial begin
    app_rdy           = 1'b0;
    app_wdf_rdy       = 1'b0;
    app_rd_data_valid = 1'b0;
    app_rd_data       = '0;
    check_errs        = 0;
    cyc               = 0;
    pass_seen         = 0;
  end

  // --------------------
  // command and write data acceptance
  // --------------------
  always @(posedge clk) begin
    logic [31:0] beat;
    logic [31:0] word;
    if (new_run) pass_seen = 0;
    if (!reset && app_wdf_wren && app_wdf_rdy) begin
      if (app_addr == range_lo) pass_seen = pass_seen + 1; // a new pass starts at the bottom
      beat = 32'((app_addr - range_lo) >> 3);
      word = check_seed + beat + ((pass_seen - 32'd1) << 16);
      assert (app_addr >= range_lo && app_addr <= range_hi && app_wdf_end) else begin
        $display("write outside the range or without wdf_end at address %h", app_addr);
        check_errs = check_errs + 1;
      end
      assert (app_wdf_data == {word, word}) else begin
        $display("ERR write_pattern expected %h actual %h", {word, word}, app_wdf_data);
        check_errs = check_errs + 1;
      end
      mem[app_addr] = app_wdf_data;
    end
    if (!reset && app_en && app_rdy && app_cmd == cmd_read) begin
      rd_q.push_back(app_addr);
      due_q.push_back(cyc + 2 + $urandom_range(0, 9)); // latency varies per read
    end
  end

  // ready stalls and read returns change on the falling edge
  always @(negedge clk) begin
    logic [ui_addr_w-1:0] a;
    logic [ui_data_w-1:0] d;
    cyc               = cyc + 1;
    app_rd_data_valid = 1'b0;
    if (reset) begin
      app_rdy     = 1'b0;
      app_wdf_rdy = 1'b0;
      rd_q.delete();
      due_q.delete();
    end else begin
      app_rdy     = !stall_en || ($urandom_range(0, 3) != 0);
      app_wdf_rdy = !stall_en || ($urandom_range(0, 3) != 0);
      if (rd_q.size() > 0 && due_q[0] <= cyc) begin
        a = rd_q.pop_front();
        void'(due_q.pop_front());
        d = mem.exists(a) ? mem[a] : '0;
        if (fault_en && a == fault_addr) d[5] = ~d[5]; // single bit fault
        app_rd_data       = d;
        app_rd_data_valid = 1'b1;
      end
    end
  end

endmodule

// ==== tb/tb_mem_tester.sv ====
`timescale 1ns/1ps

module tb_mem_tester import mem_ui_pkg::*, tester_regs_pkg::*;;

  localparam int total_beats    = 16 * (1 + 3 + 2 + 3);
  localparam int timeout_cycles = total_beats * 2 * 24 + 4000; // 24 cycles per op worst case

  logic clk, reset;
  logic [axil_addr_w-1:0] s_awaddr, s_araddr;
  logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic s_arvalid, s_arready, s_rvalid, s_rready;
  logic [31:0] s_wdata, s_rdata;
  logic [3:0] s_wstrb;
  logic [1:0] s_bresp, s_rresp;
  logic app_rdy, app_en, app_wdf_rdy, app_wdf_wren, app_wdf_end, app_rd_data_valid;
  logic [2:0] app_cmd;
  logic [ui_addr_w-1:0] app_addr, fault_addr, range_lo, range_hi;
  logic [ui_data_w-1:0] app_wdf_data, app_rd_data;
  logic error, heartbeat, busy, hb_q;
  logic stall_en, new_run, fault_en, bp_en;
  logic [31:0] check_seed;
  int check_errs, errs, tests_ok, tests_bad, hb_toggles;
  string test_name;

  mem_tester_top u_mem_tester_top (.*);

  ui_mem_model u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    hb_q <= reset ? 1'b0 : heartbeat;
    if (reset)
      hb_toggles <= 0;
    else if (heartbeat != hb_q)
      hb_toggles <= hb_toggles + 1;
  end

  // responses must hold while the master stalls
  a_b_held: assert property (@(posedge clk) disable iff (reset)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
    else begin $display("write response dropped before bready"); errs++; end
  a_r_held: assert property (@(posedge clk) disable iff (reset)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else begin $display("read data changed before rready"); errs++; end

  // --------------------
  // register port tasks
  // --------------------
  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s expected %h actual %h", test_name, name, exp, act);
      errs++;
    end
  endtask

  task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data);
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    do @(negedge clk); while (!s_awready);
    expect_eq("wready", 32'd1, 32'(s_wready)); // data is taken with the address
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    if (bp_en) repeat ($urandom_range(0, 6)) @(negedge clk);
    while (!s_bvalid) @(negedge clk);
    expect_eq("bresp", 32'd0, 32'(s_bresp)); // OKAY
    s_bready = 1'b1;
    @(negedge clk);
    s_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [axil_addr_w-1:0] addr, output logic [31:0] data);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    while (!s_arready) @(negedge clk);
    @(negedge clk);
    s_arvalid = 1'b0;
    if (bp_en) repeat ($urandom_range(0, 6)) @(negedge clk);
    while (!s_rvalid) @(negedge clk);
    data     = s_rdata;
    expect_eq("rresp", 32'd0, 32'(s_rresp)); // OKAY
    s_rready = 1'b1;
    @(negedge clk);
    s_rready = 1'b0;
  endtask

  task automatic expect_reg(input string name, input logic [axil_addr_w-1:0] ofs,
                            input logic [31:0] exp);
    logic [31:0] v;
    axil_read(ofs, v);
    expect_eq(name, exp, v);
  endtask

  task automatic report_test(input int errs_before);
    if (errs + check_errs == errs_before) begin
      tests_ok++;
      $display("test %s ok", test_name);
    end else begin
      tests_bad++;
      $display("test %s had errors", test_name);
    end
  endtask

  // program a run, start it and wait for busy to rise and fall
  task automatic run_passes(input logic [ui_addr_w-1:0] lo, input int beats, input int passes,
                            input logic [31:0] seed, input logic stop);
    range_lo   = lo;
    range_hi   = lo + 27'((beats - 1) * 8);
    check_seed = seed;
    axil_write(start_addr_ofs, 32'(range_lo));
    axil_write(end_addr_ofs, 32'(range_hi));
    axil_write(passes_ofs, 32'(passes));
    axil_write(seed_ofs, seed);
    new_run = 1'b1;
    @(negedge clk);
    new_run = 1'b0;
    axil_write(ctrl_ofs, {30'd0, stop, 1'b1});
    while (!busy) @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  initial begin
    int e0, hb0;
    logic [31:0] v;
    void'($urandom(10774));
    reset = 1'b1;
    {s_awaddr, s_araddr, s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready} = '0;
    s_wdata = '0;
    s_wstrb = 4'hF;
    {stall_en, new_run, fault_en, bp_en} = '0;
    fault_addr = '0;
    range_lo = '0;
    range_hi = '0;
    check_seed = '0;
    {errs, tests_ok, tests_bad} = '0;
    test_name = "reset";
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_name = "register_access";
    e0 = errs + check_errs;
    axil_write(start_addr_ofs, 32'h0000_0100);
    axil_write(end_addr_ofs, 32'h0000_0178);
    axil_write(passes_ofs, 32'd7);
    axil_write(seed_ofs, 32'hCAFE_0001);
    expect_reg("start_addr", start_addr_ofs, 32'h0000_0100);
    expect_reg("end_addr", end_addr_ofs, 32'h0000_0178);
    expect_reg("passes", passes_ofs, 32'd7);
    expect_reg("seed", seed_ofs, 32'hCAFE_0001);
    expect_reg("unused", 6'h24, 32'd0);
    report_test(e0);

    test_name = "single_pass";
    e0 = errs + check_errs;
    run_passes(27'h100, 16, 1, 32'h1234_0000, 1'b0);
    expect_reg("status", status_ofs, 32'h0000_000A); // done and one heartbeat toggle
    expect_reg("pass_cnt", pass_cnt_ofs, 32'd1);
    expect_reg("err_cnt", err_cnt_ofs, 32'd0);
    expect_eq("error_out", 32'd0, 32'(error));
    report_test(e0);

    test_name = "multi_pass_stalls";
    e0 = errs + check_errs;
    stall_en = 1'b1;
    hb0 = hb_toggles;
    run_passes(27'h2000, 16, 3, 32'hA5A5_0000, 1'b0);
    expect_reg("pass_cnt", pass_cnt_ofs, 32'd3);
    expect_eq("heartbeat_toggles", 32'd3, 32'(hb_toggles - hb0));
    report_test(e0);

    test_name = "fault_injection";
    e0 = errs + check_errs;
    fault_en   = 1'b1;
    fault_addr = 27'h3000 + 27'd40;
    run_passes(27'h3000, 16, 2, 32'h0BAD_0000, 1'b0);
    expect_reg("err_cnt", err_cnt_ofs, 32'd2);
    expect_reg("first_err_addr", first_err_addr_ofs, 32'(fault_addr));
    expect_eq("error_out", 32'd1, 32'(error));
    report_test(e0);

    test_name = "stop_on_error";
    e0 = errs + check_errs;
    run_passes(27'h3000, 16, 3, 32'h0BAD_0000, 1'b1);
    expect_reg("pass_cnt", pass_cnt_ofs, 32'd1);
    expect_reg("err_cnt", err_cnt_ofs, 32'd1);
    expect_eq("busy_out", 32'd0, 32'(busy));
    report_test(e0);

    test_name = "back_pressure";
    e0 = errs + check_errs;
    fault_en = 1'b0;
    bp_en    = 1'b1;
    for (int i = 0; i < 6; i++) begin
      v = $urandom();
      axil_write(seed_ofs, v);
      expect_reg("seed_bp", seed_ofs, v);
    end
    expect_reg("passes_bp", passes_ofs, 32'd3);
    report_test(e0);

    $display("%0d tests ok, %0d tests with errors, %0d check errors",
             tests_ok, tests_bad, errs + check_errs);
    if (tests_bad == 0 && errs + check_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * 8);
    $display("watchdog expired before the test sequence finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/mem_ui_pkg.sv
design/tester_regs_pkg.sv
design/ui_traffic_gen.sv
design/rd_data_checker.sv
design/tester_csr.sv
design/mem_tester_top.sv
tb/ui_mem_model.sv
tb/tb_mem_tester.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_tester
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FILELIST := vlog.f
SRCS     := $(shell cat $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
